// File: hdl/buffer_cfg_pkg.sv
// Sizing of the stream buffer data path and its status thresholds
package buffer_cfg_pkg;

  // Stream word width
  localparam int DATA_WIDTH = 8;

  // SRAM address width and the resulting number of SRAM words
  localparam int ADDR_BITS = 4;
  localparam int DEPTH     = 1 << ADDR_BITS;

  // Occupancy width
  // One extra bit, since the SRAM output register and the two skid
  // registers hold words on top of a full SRAM
  localparam int LEVEL_BITS = ADDR_BITS + 1;

  // Output pipeline of the FIFO
  //   0  asynchronous SRAM read, no extra registers
  //   1  registered SRAM read
  //   2  registered read with first-word fall-through
  //   3  as 2, with the loadable overflow register in the skid stage
  localparam int OUTREG_MODE = 3;

  // Almost full at or above this level
  localparam logic [LEVEL_BITS-1:0] HIGH_MARK = LEVEL_BITS'(12);

  // Almost empty at or below this level
  localparam logic [LEVEL_BITS-1:0] LOW_MARK = LEVEL_BITS'(3);

endpackage

// File: hdl/buffer_status_pkg.sv
// Status types reported by the stream buffer
package buffer_status_pkg;

  // Fill state of the buffer as tracked by the watermark FSM
  //   LEVEL_LOW   level at or below the low mark
  //   LEVEL_MID   level between the marks
  //   LEVEL_HIGH  level at or above the high mark
  // Between the marks the previous state is kept
  typedef enum logic [1:0] {
    LEVEL_LOW  = 2'd0,
    LEVEL_MID  = 2'd1,
    LEVEL_HIGH = 2'd2
  } level_state_t;

endpackage

// File: hdl/skid_loader.sv
`timescale 1ns/1ps

// Two-entry skid register between a valid/ready source and sink
module skid_loader #(
  parameter int WIDTH  = 8,
  // Set to pass the s port straight to the m port
  parameter int BYPASS = 0,
  // Set to allow the t port to fill the temporary register
  parameter int LOADER = 0
) (
  input  logic             clock_i,
  input  logic             reset_i,

  // Upstream port
  input  logic             s_valid_i,
  input  logic [WIDTH-1:0] s_data_i,
  output logic             s_ready_o,

  // Load-only port into the temporary register
  input  logic             t_valid_i,
  input  logic [WIDTH-1:0] t_data_i,
  output logic             t_ready_o,

  // Downstream port
  output logic             m_valid_o,
  output logic [WIDTH-1:0] m_data_o,
  input  logic             m_ready_i
);

  generate
    if (BYPASS != 0) begin : g_bypass

      // Plain wires, the source sees the sink's ready directly
      assign m_valid_o = s_valid_i;
      assign m_data_o  = s_data_i;
      assign s_ready_o = m_ready_i;

      // Nothing to load into
      assign t_ready_o = 1'b0;

    end else begin : g_skid

      // Output register
      logic             m_valid_q;
      logic [WIDTH-1:0] m_data_q;

      // Temporary register, catches the word that arrives while the
      // output register is stalled
      logic             t_valid_q;
      logic [WIDTH-1:0] t_data_q;

      logic             m_free_w;
      logic             s_xfer_w;
      logic             t_xfer_w;

      // Output register empty or being taken at this edge
      assign m_free_w  = !m_valid_q || m_ready_i;

      // Upstream ready comes straight from a flop
      assign s_ready_o = !t_valid_q;
      assign s_xfer_w  = s_valid_i && !t_valid_q;

      // Temporary register can take a word next to the s word,
      // which then goes into the output register
      assign t_ready_o = (LOADER != 0) && !t_valid_q && m_free_w;

      // A t word is only taken together with an s word, so that it
      // always lines up behind it
      assign t_xfer_w  = t_valid_i && t_ready_o && s_valid_i;

      // Occupancy of both registers
      always_ff @(posedge clock_i) begin
        if (reset_i) begin
          m_valid_q <= 1'b0;
          t_valid_q <= 1'b0;
        end else if (m_free_w) begin
          // Refill from temp first, then from the s port
          m_valid_q <= t_valid_q || s_xfer_w;
          t_valid_q <= t_xfer_w;
        end else if (s_xfer_w) begin
          // Output stalled, park the s word
          t_valid_q <= 1'b1;
        end
      end

      // Payload follows the same steering
      always_ff @(posedge clock_i) begin
        if (m_free_w) begin
          if (t_valid_q) begin
            m_data_q <= t_data_q;
          end else if (s_xfer_w) begin
            m_data_q <= s_data_i;
          end
          if (t_xfer_w) begin
            t_data_q <= t_data_i;
          end
        end else if (s_xfer_w) begin
          t_data_q <= s_data_i;
        end
      end

      assign m_valid_o = m_valid_q;
      assign m_data_o  = m_data_q;

    end
  endgenerate

endmodule

// File: hdl/sync_fifo.sv
`timescale 1ns/1ps

// Synchronous SRAM FIFO with valid/ready on both sides
module sync_fifo #(
  // Output pipeline, 0 to 3
  parameter int OUTREG = buffer_cfg_pkg::OUTREG_MODE
) (
  input  logic                                  clock_i,
  input  logic                                  reset_i,

  // Producer side
  input  logic                                  valid_i,
  output logic                                  ready_o,
  input  logic [buffer_cfg_pkg::DATA_WIDTH-1:0] data_i,

  // Consumer side
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output logic [buffer_cfg_pkg::DATA_WIDTH-1:0] data_o,

  // Words accepted minus words delivered
  output logic [buffer_cfg_pkg::LEVEL_BITS-1:0] level_o
);

  import buffer_cfg_pkg::*;

  logic [DATA_WIDTH-1:0] sram [DEPTH];

  // Pointers carry one wrap bit above the address
  logic [ADDR_BITS:0]    waddr_q;
  logic [ADDR_BITS:0]    raddr_q;
  logic [ADDR_BITS:0]    waddr_nx;
  logic [ADDR_BITS:0]    raddr_nx;

  // Registered SRAM status
  logic                  wready_q;
  logic                  rvalid_q;
  logic                  full_nx;
  logic                  empty_nx;

  // SRAM write and read strobes
  logic                  store_w;
  logic                  fetch_w;

  // Occupancy count
  logic                  incr_w;
  logic                  decr_w;
  logic [LEVEL_BITS-1:0] level_q;

  assign ready_o = wready_q;
  assign level_o = level_q;

  // Pointer values after this edge
  assign waddr_nx = store_w ? waddr_q + 1'b1 : waddr_q;
  assign raddr_nx = fetch_w ? raddr_q + 1'b1 : raddr_q;

  // Predict the status after this edge, so ready and valid are flops
  // Full when the addresses match and the wrap bits differ
  assign full_nx  = (waddr_nx[ADDR_BITS] != raddr_nx[ADDR_BITS]) &&
                    (waddr_nx[ADDR_BITS-1:0] == raddr_nx[ADDR_BITS-1:0]);
  assign empty_nx = waddr_nx == raddr_nx;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      waddr_q  <= '0;
      raddr_q  <= '0;
      wready_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      waddr_q  <= waddr_nx;
      raddr_q  <= raddr_nx;
      wready_q <= !full_nx;
      rvalid_q <= !empty_nx;
    end
  end

  // SRAM write port
  always_ff @(posedge clock_i) begin
    if (store_w) begin
      sram[waddr_q[ADDR_BITS-1:0]] <= data_i;
    end
  end

  // Count every stream transfer, wherever the word is held
  assign incr_w = valid_i && wready_q;
  assign decr_w = valid_o && ready_i;

  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      level_q <= '0;
    end else begin
      case ({incr_w, decr_w})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  generate
    if (OUTREG == 0) begin : g_async

      // Asynchronous read, the SRAM word is the output
      assign store_w = valid_i && wready_q;
      assign fetch_w = rvalid_q && ready_i;
      assign valid_o = rvalid_q;
      assign data_o  = sram[raddr_q[ADDR_BITS-1:0]];

    end else begin : g_outreg

      // SRAM read register
      logic                  xvalid_q;
      logic [DATA_WIDTH-1:0] xdata_q;
      logic                  xmove_w;

      // Skid stage ports
      logic                  svalid_w;
      logic                  sready_w;
      logic [DATA_WIDTH-1:0] sdata_w;
      logic                  tvalid_w;
      logic                  tready_w;

      // Routing of the incoming word
      logic                  fall_w;
      logic                  ft_w;
      logic                  ld_w;

      // Read register hands its word to the skid stage
      assign xmove_w  = xvalid_q && sready_w;

      // Read whenever the read register is free or about to be
      assign fetch_w  = rvalid_q && (!xvalid_q || sready_w);

      // Nothing queued in the SRAM path, the word may skip it
      assign fall_w   = (OUTREG > 1) && !rvalid_q && !xvalid_q && valid_i && wready_q;
      assign ft_w     = fall_w && sready_w;

      // SRAM empty but its last word is leaving the read register
      // The new word goes into the temp register right behind it
      assign tvalid_w = (OUTREG > 2) && !rvalid_q && xvalid_q && valid_i && wready_q;
      assign ld_w     = tvalid_w && tready_w;

      // Anything else is queued in the SRAM
      assign store_w  = valid_i && wready_q && !ft_w && !ld_w;

      // Read register wins the s port over the incoming word
      assign svalid_w = xvalid_q || fall_w;
      assign sdata_w  = xvalid_q ? xdata_q : data_i;

      always_ff @(posedge clock_i) begin
        if (reset_i) begin
          xvalid_q <= 1'b0;
        end else if (fetch_w) begin
          xvalid_q <= 1'b1;
        end else if (xmove_w) begin
          xvalid_q <= 1'b0;
        end
      end

      // Registered SRAM read
      always_ff @(posedge clock_i) begin
        if (fetch_w) begin
          xdata_q <= sram[raddr_q[ADDR_BITS-1:0]];
        end
      end

      // Mode 1 passes the read register straight out
      skid_loader #(
        .WIDTH  (DATA_WIDTH),
        .BYPASS (OUTREG > 1 ? 0 : 1),
        .LOADER (OUTREG > 2 ? 1 : 0)
      ) skid_inst (
        .clock_i   (clock_i),
        .reset_i   (reset_i),
        .s_valid_i (svalid_w),
        .s_data_i  (sdata_w),
        .s_ready_o (sready_w),
        .t_valid_i (tvalid_w),
        .t_data_i  (data_i),
        .t_ready_o (tready_w),
        .m_valid_o (valid_o),
        .m_data_o  (data_o),
        .m_ready_i (ready_i)
      );

    end
  endgenerate

endmodule

// File: hdl/level_watermark.sv
`timescale 1ns/1ps

// Almost-full and almost-empty flags with hysteresis between two marks
module level_watermark (
  input  logic                                  clock_i,
  input  logic                                  reset_i,
  input  logic [buffer_cfg_pkg::LEVEL_BITS-1:0] level_i,
  output logic                                  almost_full_o,
  output logic                                  almost_empty_o,
  output buffer_status_pkg::level_state_t       state_o
);

  import buffer_cfg_pkg::*;
  import buffer_status_pkg::*;

  level_state_t state_q;
  level_state_t state_nx;
  logic         full_q;
  logic         empty_q;

  // Level moves by at most one per cycle, so MID is always passed through
  always_comb begin
    state_nx = state_q;
    case (state_q)
      LEVEL_LOW: begin
        if (level_i > LOW_MARK) begin
          state_nx = LEVEL_MID;
        end
      end
      LEVEL_MID: begin
        if (level_i >= HIGH_MARK) begin
          state_nx = LEVEL_HIGH;
        end else if (level_i <= LOW_MARK) begin
          state_nx = LEVEL_LOW;
        end
      end
      LEVEL_HIGH: begin
        // Held until the level is back down at the low mark
        if (level_i <= LOW_MARK) begin
          state_nx = LEVEL_MID;
        end
      end
      default: state_nx = LEVEL_LOW;
    endcase
  end

  // Flags are decoded from the next state, so they switch with state_o
  always_ff @(posedge clock_i) begin
    if (reset_i) begin
      state_q <= LEVEL_LOW;
      full_q  <= 1'b0;
      empty_q <= 1'b1;
    end else begin
      state_q <= state_nx;
      full_q  <= state_nx == LEVEL_HIGH;
      empty_q <= state_nx == LEVEL_LOW;
    end
  end

  assign state_o        = state_q;
  assign almost_full_o  = full_q;
  assign almost_empty_o = empty_q;

endmodule

// File: hdl/stream_buffer.sv
`timescale 1ns/1ps

// Stream buffer, FIFO plus fill-level watermark
module stream_buffer (
  input  logic                                  clock_i,
  input  logic                                  reset_i,

  // Producer side
  input  logic                                  valid_i,
  input  logic [buffer_cfg_pkg::DATA_WIDTH-1:0] data_i,
  output logic                                  ready_o,

  // Consumer side
  output logic                                  valid_o,
  output logic [buffer_cfg_pkg::DATA_WIDTH-1:0] data_o,
  input  logic                                  ready_i,

  // Fill status for upstream throttling
  output logic [buffer_cfg_pkg::LEVEL_BITS-1:0] level_o,
  output logic                                  almost_full_o,
  output logic                                  almost_empty_o,
  output buffer_status_pkg::level_state_t       state_o
);

  import buffer_cfg_pkg::*;

  // Data path and occupancy count
  sync_fifo #(
    .OUTREG (OUTREG_MODE)
  ) fifo_inst (
    .clock_i (clock_i),
    .reset_i (reset_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .valid_o (valid_o),
    .ready_i (ready_i),
    .data_o  (data_o),
    .level_o (level_o)
  );

  // Watermark flags, one cycle behind the count
  level_watermark watermark_inst (
    .clock_i        (clock_i),
    .reset_i        (reset_i),
    .level_i        (level_o),
    .almost_full_o  (almost_full_o),
    .almost_empty_o (almost_empty_o),
    .state_o        (state_o)
  );

endmodule

// File: tb/stream_buffer_tb.sv
`timescale 1ns/1ps

module stream_buffer_tb;

  import buffer_cfg_pkg::*;
  import buffer_status_pkg::*;

  logic                  clock;
  logic                  reset;
  logic                  valid_i;
  logic [DATA_WIDTH-1:0] data_i;
  logic                  ready_o;
  logic                  valid_o;
  logic [DATA_WIDTH-1:0] data_o;
  logic                  ready_i;
  logic [LEVEL_BITS-1:0] level_o;
  logic                  almost_full_o;
  logic                  almost_empty_o;
  level_state_t          state_o;

  // Reference model and expected words from the file
  logic [DATA_WIDTH-1:0] model_q[$];
  logic [DATA_WIDTH-1:0] exp_q[$];
  int                    model_count;
  int                    lvl_prev;
  level_state_t          exp_state;

  // Phases read from the stimulus file
  logic [7:0]            ph_kind[$];
  int                    ph_a[$];
  int                    ph_b[$];
  int                    ph_c[$];

  logic                  acc_now;
  logic                  del_now;
  int                    edge_idx;
  int                    err_cnt;
  int                    delivered;
  int                    cycle_cnt;
  int                    cycle_limit;

  stream_buffer stream_buffer_inst (
    .clock_i        (clock),
    .reset_i        (reset),
    .valid_i        (valid_i),
    .data_i         (data_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .data_o         (data_o),
    .ready_i        (ready_i),
    .level_o        (level_o),
    .almost_full_o  (almost_full_o),
    .almost_empty_o (almost_empty_o),
    .state_o        (state_o)
  );

  always #5 clock = ~clock;

  // Run limit
  always @(posedge clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped moving words", cycle_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] want,
                                 input logic [31:0] got);
    $display("ERROR at %0d ns: %s expected %0h, got %0h", $time, name, want, got);
    err_cnt++;
  endtask

  // Hysteresis between the marks, one step per cycle
  function automatic level_state_t watermark_step(input level_state_t s, input int lvl);
    if (s == LEVEL_HIGH) begin
      return (lvl <= LOW_MARK) ? LEVEL_MID : LEVEL_HIGH;
    end
    if (s == LEVEL_MID) begin
      if (lvl >= HIGH_MARK) begin
        return LEVEL_HIGH;
      end
      return (lvl <= LOW_MARK) ? LEVEL_LOW : LEVEL_MID;
    end
    return (lvl > LOW_MARK) ? LEVEL_MID : LEVEL_LOW;
  endfunction

  task automatic check_reset_values();
    if (valid_o !== 1'b0) report_mismatch("valid_o", 0, valid_o);
    if (ready_o !== 1'b0) report_mismatch("ready_o", 0, ready_o);
    if (almost_full_o !== 1'b0) report_mismatch("almost_full_o", 0, almost_full_o);
    if (almost_empty_o !== 1'b1) report_mismatch("almost_empty_o", 1, almost_empty_o);
  endtask

  // Outputs are stable at the falling edge, they reflect the last rising edge
  task automatic sample_outputs();
    @(negedge clock);
    // Flags lag the count by one more cycle
    exp_state = watermark_step(exp_state, lvl_prev);
    if (level_o !== LEVEL_BITS'(model_count)) report_mismatch("level_o", model_count, level_o);
    if (state_o !== exp_state) report_mismatch("state_o", exp_state, state_o);
    if (almost_full_o !== (exp_state == LEVEL_HIGH)) begin
      report_mismatch("almost_full_o", exp_state == LEVEL_HIGH, almost_full_o);
    end
    if (almost_empty_o !== (exp_state == LEVEL_LOW)) begin
      report_mismatch("almost_empty_o", exp_state == LEVEL_LOW, almost_empty_o);
    end
    lvl_prev = model_count;
  endtask

  // Drive the next cycle and predict the transfers of the coming edge
  task automatic drive_inputs(input logic v, input logic [DATA_WIDTH-1:0] d, input logic r);
    logic [DATA_WIDTH-1:0] want;
    valid_i  = v;
    data_i   = d;
    ready_i  = r;
    acc_now  = v && ready_o;
    del_now  = valid_o && r;
    edge_idx++;
    if (del_now) begin
      if (model_q.size() == 0) begin
        $display("Word %0h delivered at %0d ns with nothing outstanding", data_o, $time);
        err_cnt++;
      end else begin
        want = model_q.pop_front();
        if (data_o !== want) report_mismatch("data_o", want, data_o);
      end
      if (exp_q.size() == 0) begin
        $display("Word %0h delivered beyond the expected list at %0d ns", data_o, $time);
        err_cnt++;
      end else begin
        want = exp_q.pop_front();
        if (data_o !== want) report_mismatch("data_o (file)", want, data_o);
      end
      delivered++;
    end
    if (acc_now) model_q.push_back(d);
    model_count = model_q.size();
  endtask

  task automatic idle_cycles(input int n, input logic r);
    repeat (n) begin
      sample_outputs();
      drive_inputs(1'b0, '0, r);
    end
  endtask

  // Producer holds each word until it is taken
  task automatic send_burst(input int n, input int first, input int rmode);
    int   sent;
    int   k;
    logic r;
    sent = 0;
    k    = 0;
    while (sent < n) begin
      r = (rmode == 2) ? ((k % 2) == 1) : (rmode == 1);
      sample_outputs();
      drive_inputs(1'b1, DATA_WIDTH'(first + sent), r);
      if (acc_now) sent++;
      k++;
    end
  endtask

  // Consumer stalled, push until ready_o drops
  task automatic fill_until_stall(input int first);
    int sent;
    sent = 0;
    sample_outputs();
    while (ready_o === 1'b1) begin
      drive_inputs(1'b1, DATA_WIDTH'(first + sent), 1'b0);
      if (acc_now) sent++;
      sample_outputs();
    end
    drive_inputs(1'b0, '0, 1'b0);
    if (sent < DEPTH) begin
      $display("ready_o fell after %0d words, before the SRAM could be full", sent);
      err_cnt++;
    end
  endtask

  // One word into an empty buffer, mode 3 delivers on the next edge
  task automatic single_word_latency(input int first);
    int acc_edge;
    int del_edge;
    if (model_count != 0) begin
      $display("Buffer holds %0d words before the latency test", model_count);
      err_cnt++;
    end
    acc_edge = -1;
    del_edge = -1;
    while (del_edge < 0) begin
      sample_outputs();
      drive_inputs(acc_edge < 0, DATA_WIDTH'(first), 1'b1);
      if (del_now && acc_edge >= 0) del_edge = edge_idx;
      if (acc_now) acc_edge = edge_idx;
    end
    if (del_edge != acc_edge + 1) report_mismatch("valid_o latency", 1, del_edge - acc_edge);
  endtask

  initial begin
    int         fd;
    int         rc;
    string      line;
    logic [7:0] tag;
    int         a;
    int         b;
    int         c;
    int         p;
    int         gap;
    int         stim_len;
    int         seed_val;
    clock       = 1'b0;
    reset       = 1'b1;
    valid_i     = 1'b0;
    data_i      = '0;
    ready_i     = 1'b0;
    err_cnt     = 0;
    delivered   = 0;
    edge_idx    = 0;
    cycle_cnt   = 0;
    model_count = 0;
    lvl_prev    = 0;
    exp_state   = LEVEL_LOW;
    stim_len    = 0;
    seed_val    = $urandom(32'h219e_50b8);

    fd = $fopen("tb/stream_buffer_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open tb/stream_buffer_stimulus.txt");
      err_cnt++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        a    = 0;
        b    = 0;
        c    = 0;
        if (line.len() > 1 && line.getc(0) != "#") begin
          rc = $sscanf(line, "%c %h %h %h", tag, a, b, c);
          if (tag == "E") begin
            for (int w = a; w <= b; w++) exp_q.push_back(DATA_WIDTH'(w));
          end else begin
            ph_kind.push_back(tag);
            ph_a.push_back(a);
            ph_b.push_back(b);
            ph_c.push_back(c);
            // Rough cycle cost of each phase, gaps included
            case (tag)
              "B":     stim_len += 2 * a + 4;
              "W":     stim_len += a + 4;
              "F":     stim_len += DEPTH + 8;
              default: stim_len += 6;
            endcase
          end
        end
      end
      $fclose(fd);
    end
    cycle_limit = 4 * stim_len + 200;

    // Reset for 5 cycles
    repeat (5) begin
      @(negedge clock);
      check_reset_values();
    end
    reset = 1'b0;
    sample_outputs();
    if (ready_o !== 1'b1) report_mismatch("ready_o", 1, ready_o);
    drive_inputs(1'b0, '0, 1'b1);

    for (p = 0; p < ph_kind.size(); p++) begin
      case (ph_kind[p])
        "B":     send_burst(ph_a[p], ph_b[p], ph_c[p]);
        "W":     idle_cycles(ph_a[p], ph_b[p] != 0);
        "F":     fill_until_stall(ph_a[p]);
        "S":     single_word_latency(ph_a[p]);
        default: begin
          $display("Unknown phase tag %0h in the stimulus file", ph_kind[p]);
          err_cnt++;
        end
      endcase
      // Random idle gap with the consumer ready
      gap = $urandom % 4;
      idle_cycles(gap, 1'b1);
    end

    if (model_q.size() != 0) begin
      $display("%0d accepted words were never delivered", model_q.size());
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected words never arrived", exp_q.size());
      err_cnt++;
    end
    $display("Run complete: %0d words delivered, %0d errors", delivered, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: stream_buffer.f
hdl/buffer_cfg_pkg.sv
hdl/buffer_status_pkg.sv
hdl/skid_loader.sv
hdl/sync_fifo.sv
hdl/level_watermark.sv
hdl/stream_buffer.sv
tb/stream_buffer_tb.sv

// File: tb/stream_buffer_stimulus.txt
# B count first ready: burst of count words from first, ready 0 low, 1 high, 2 toggling
# W count ready: idle cycles; S first: single word latency; F first: fill until ready_o falls
# E first last: expected output words first to last, in order (all numbers hex)
S 10
W 04 1
B 08 20 1
B 18 28 2
W 20 1
F 40
W 30 1
B 0c 60 2
B 0a 70 0
W 30 1
S 80
W 06 1
E 10 10
E 20 27
E 28 3f
E 40 52
E 60 6b
E 70 79
E 80 80
